//--- build.f
+incdir+include
verilog/icache_pkg.sv
verilog/icache_controller.sv
verilog/icache_mem.sv
verilog/icache_perf_counters.sv
verilog/icache_top.sv
verification/icache_checker.sv
verification/imem_model.sv
verification/icache_tb.sv

//--- Bender.yml
package:
  name: icache

export_include_dirs:
  - include

sources:
  - files:
      - verilog/icache_pkg.sv
      - verilog/icache_controller.sv
      - verilog/icache_mem.sv
      - verilog/icache_perf_counters.sv
      - verilog/icache_top.sv
  - target: test
    files:
      - verification/icache_checker.sv
      - verification/imem_model.sv
      - verification/icache_tb.sv

//--- verification/icache_tb.sv
`include "icache_settings.svh"

module icache_tb;
	import icache_pkg::*;

	localparam int pool_size   = 48;
	localparam int fetch_count = 400;
	localparam int hit_timeout = 300;

	logic         clock;
	logic         reset;
	addr_t        fetch_addr;
	mem_tag_t     mem_response;
	word_t        mem_data;
	mem_tag_t     mem_tag;
	word_t        fetch_data;
	logic         fetch_valid;
	bus_command_t mem_command;
	addr_t        mem_addr;
	count_t       lookup_count;
	count_t       miss_count;
	count_t       fill_count;

	logic         model_valid [`ICACHE_LINES];    // Reference cache contents.
	tag_t         model_tag [`ICACHE_LINES];
	index_t       prev_index;
	tag_t         prev_tag;
	logic         prev_miss;
	mem_tag_t     held_tag;
	int           lookups = 0;
	int           misses = 0;
	int           fills = 0;
	addr_t        pool [pool_size];

	icache_top icache_top_inst
	(
		.clock        (clock),
		.reset        (reset),
		.fetch_addr   (fetch_addr),
		.mem_response (mem_response),
		.mem_data     (mem_data),
		.mem_tag      (mem_tag),
		.fetch_data   (fetch_data),
		.fetch_valid  (fetch_valid),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.lookup_count (lookup_count),
		.miss_count   (miss_count),
		.fill_count   (fill_count)
	);

	imem_model imem_model_inst
	(
		.clock        (clock),
		.reset        (reset),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.mem_response (mem_response),
		.mem_data     (mem_data),
		.mem_tag      (mem_tag)
	);

	bind icache_controller icache_checker icache_checker_inst
	(
		.clock         (clock),
		.reset         (reset),
		.state         (state),
		.mem_command   (mem_command),
		.mem_response  (mem_response),
		.current_index (current_index),
		.current_tag   (current_tag),
		.fill_enable   (fill_enable)
	);

	initial
		clock = 1'b0;

	always
		#50 clock = ~clock;

	////////////////////
	// Helpers
	////////////////////

	function automatic word_t expected_word(addr_t line_addr);
		return (line_addr * 64'h9E37_79B9_7F4A_7C15) ^ {line_addr[31:0], line_addr[63:32]};
	endfunction

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("** Error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	task automatic wait_for_hit();
		int cycles = 0;
		@(negedge clock);
		while (!fetch_valid)
		begin
			if (cycles == hit_timeout)
			begin
				$display("fetch_valid stayed low for %0d cycles at time %0t", hit_timeout, $time);
				abort_run();
			end
			cycles++;
			@(negedge clock);
		end
	endtask

	////////////////////
	// Reference model
	////////////////////

	always @(negedge clock)
	begin : reference_model
		index_t       cur_index;
		tag_t         cur_tag;
		addr_t        line_addr;
		logic         changed;
		logic         hit;
		bus_command_t expected_command;

		cur_index = fetch_addr[7:3];
		cur_tag   = fetch_addr[15:8];
		line_addr = fetch_addr & ~addr_t'(7);
		check_value("lookup_count", lookup_count, 64'(lookups));    // Events of earlier cycles.
		check_value("miss_count", miss_count, 64'(misses));
		check_value("fill_count", fill_count, 64'(fills));
		if (icache_top_inst.icache_controller_inst.icache_checker_inst.failure_count != 0)
		begin
			$display("A bus protocol assertion failed before time %0t", $time);
			abort_run();
		end
		if (reset)
		begin
			check_value("mem_command", mem_command, bus_none);
			for (int i = 0; i < `ICACHE_LINES; i++)
				model_valid[i] = 1'b0;
			prev_index = '1;    // First address is a change.
			prev_tag   = '1;
			prev_miss  = 1'b0;
			held_tag   = '0;
		end
		else
		begin
			changed = (cur_index != prev_index) || (cur_tag != prev_tag);
			hit     = model_valid[cur_index] && (model_tag[cur_index] == cur_tag);
			check_value("fetch_valid", fetch_valid, hit);
			if (hit)
				check_value("fetch_data", fetch_data, expected_word(line_addr));
			// Load goes out from the second miss cycle until a tag is granted.
			if (!changed && !hit && prev_miss && held_tag == '0)
				expected_command = bus_load;
			else
				expected_command = bus_none;
			check_value("mem_command", mem_command, expected_command);
			if (mem_command == bus_load)
				check_value("mem_addr", mem_addr, line_addr);
			if (changed)
				held_tag = '0;    // Miss abandoned.
			else if (held_tag != '0 && mem_tag == held_tag)
			begin
				model_valid[cur_index] = 1'b1;
				model_tag[cur_index]   = cur_tag;
				fills++;
				held_tag = '0;
			end
			if (expected_command == bus_load && mem_response != '0)
			begin
				held_tag = mem_response;
				misses++;
			end
			if (changed)
				lookups++;
			prev_index = cur_index;
			prev_tag   = cur_tag;
			prev_miss  = !hit;
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin : stimulus
		int    pick;
		addr_t addr;

		void'($urandom(40156));
		reset      = 1'b1;
		fetch_addr = '0;
		// Three tags over a spread of indices. Half the indices are shared.
		for (int i = 0; i < pool_size; i++)
			pool[i] = 64'h0000_00A5_0000_0000 | (addr_t'(8'h40 + i % 3) << 8)
				| (addr_t'((i * 7) % 32) << 3);

		repeat (5) @(posedge clock);
		reset <= 1'b0;

		for (int n = 0; n < fetch_count; n++)
		begin
			pick = $urandom_range(pool_size - 1, 0);
			addr = pool[pick] | addr_t'($urandom_range(7, 0));    // Any byte of the line.
			fetch_addr <= addr;
			if ($urandom_range(2, 0) == 0)
				repeat ($urandom_range(40, 1)) @(posedge clock);
			else
			begin
				wait_for_hit();
				repeat ($urandom_range(3, 1)) @(posedge clock);    // Refetch hits at once.
			end
		end

		@(posedge clock);
		#10;
		check_value("lookup_count", lookup_count, 64'(lookups));
		check_value("miss_count", miss_count, 64'(misses));
		check_value("fill_count", fill_count, 64'(fills));
		if (fills == 0)
		begin
			$display("No line was filled during the run");
			abort_run();
		end
		if (icache_top_inst.icache_controller_inst.icache_checker_inst.failure_count == 0)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
		begin
			$display("A bus protocol assertion failed");
			abort_run();
		end
	end

endmodule

//--- verification/imem_model.sv
module imem_model
(
	input  logic                      clock,
	input  logic                      reset,
	input  icache_pkg::bus_command_t  mem_command,
	input  icache_pkg::addr_t         mem_addr,
	output icache_pkg::mem_tag_t      mem_response,
	output icache_pkg::word_t         mem_data,
	output icache_pkg::mem_tag_t      mem_tag
);
	import icache_pkg::*;

	mem_tag_t pending_tag [$];      // Accepted loads still in flight.
	addr_t    pending_addr [$];
	int       pending_delay [$];
	mem_tag_t next_tag;

	// Every address bit reaches the word.
	function automatic word_t word_at(addr_t line_addr);
		return (line_addr * 64'h9E37_79B9_7F4A_7C15) ^ {line_addr[31:0], line_addr[63:32]};
	endfunction

	// First nonzero tag from start that no transaction in flight still owns.
	function automatic mem_tag_t free_tag(mem_tag_t start);
		mem_tag_t candidate;
		logic     busy;
		candidate = start;
		for (int n = 0; n < 15; n++)
		begin
			if (candidate == '0)
				candidate = 1;
			busy = 1'b0;
			foreach (pending_tag[i])
				if (pending_tag[i] == candidate)
					busy = 1'b1;
			if (!busy)
				return candidate;
			candidate = candidate + 1'b1;
		end
		return '0;    // All tags busy, answer retry.
	endfunction

	initial
	begin
		mem_response = '0;
		mem_data     = '0;
		mem_tag      = '0;
		next_tag     = 1;
	end

	always @(posedge clock)
	begin : bus_cycle
		int ready;

		if (reset)
		begin
			pending_tag.delete();
			pending_addr.delete();
			pending_delay.delete();
			mem_response <= '0;
			mem_data     <= '0;
			mem_tag      <= '0;
			next_tag     = 1;
		end
		else
		begin
			foreach (pending_delay[i])
				if (pending_delay[i] != 0)
					pending_delay[i]--;    // Age the loads in flight.
			if (mem_command == bus_load && mem_response != '0)
			begin
				pending_tag.push_back(mem_response);
				pending_addr.push_back(mem_addr);
				pending_delay.push_back($urandom_range(10, 0));
				next_tag = mem_response + 1'b1;
			end
			ready = -1;
			foreach (pending_delay[i])
				if (pending_delay[i] == 0 && ready < 0)
					ready = i;
			if (ready >= 0)
			begin
				mem_tag  <= pending_tag[ready];    // One return per cycle.
				mem_data <= word_at(pending_addr[ready]);
				pending_tag.delete(ready);
				pending_addr.delete(ready);
				pending_delay.delete(ready);
			end
			else
			begin
				mem_tag  <= '0;
				mem_data <= {$urandom, $urandom};    // Idle bus carries junk.
			end
			if ($urandom_range(2, 0) == 0)
				mem_response <= free_tag(next_tag);
			else
				mem_response <= '0;    // Back-pressure.
		end
	end

endmodule

//--- verification/icache_checker.sv
module icache_checker
(
	input logic                      clock,
	input logic                      reset,
	input icache_pkg::icache_state_t state,
	input icache_pkg::bus_command_t  mem_command,
	input icache_pkg::mem_tag_t      mem_response,
	input icache_pkg::index_t        current_index,
	input icache_pkg::tag_t          current_tag,
	input logic                      fill_enable
);
	import icache_pkg::*;

	int failure_count = 0;    // Failed assertions so far.

	////////////////////
	// Bus protocol
	////////////////////

	// The first reset edge still sees the state from before reset.
	quiet_in_reset: assert property (@(posedge clock)
		(reset && $past(reset)) |-> (mem_command == bus_none))
	else
	begin
		$error("mem_command is active while reset is held");
		failure_count++;
	end

	load_held: assert property (@(posedge clock) disable iff (reset)
		(mem_command == bus_load && mem_response == '0) ##1
		($stable(current_index) && $stable(current_tag)) |-> (mem_command == bus_load))
	else
	begin
		$error("bus_load was dropped before it was accepted");
		failure_count++;
	end

	// A fill never comes from state_request and always ends the miss.
	fill_from_wait_data: assert property (@(posedge clock) disable iff (reset)
		fill_enable |-> (state == state_wait_data) ##1 (state == state_idle))
	else
	begin
		$error("fill_enable outside state_wait_data or not followed by state_idle");
		failure_count++;
	end

endmodule

//--- verilog/icache_top.sv
`include "icache_settings.svh"

module icache_top
(
	input  logic                      clock,
	input  logic                      reset,
	input  icache_pkg::addr_t         fetch_addr,
	input  icache_pkg::mem_tag_t      mem_response,
	input  icache_pkg::word_t         mem_data,
	input  icache_pkg::mem_tag_t      mem_tag,
	output icache_pkg::word_t         fetch_data,
	output logic                      fetch_valid,
	output icache_pkg::bus_command_t  mem_command,
	output icache_pkg::addr_t         mem_addr,
	output icache_pkg::count_t        lookup_count,
	output icache_pkg::count_t        miss_count,
	output icache_pkg::count_t        fill_count
);
	import icache_pkg::*;

	index_t lookup_index;
	tag_t   lookup_tag;
	logic   lookup_hit;
	index_t fill_index;
	tag_t   fill_tag;
	logic   fill_enable;
	logic   lookup_event;
	logic   miss_event;
	logic   fill_event;

	// Same fields as in the controller.
	assign lookup_index = fetch_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
	assign lookup_tag   = fetch_addr[`ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS +: `ICACHE_TAG_BITS];

	assign fetch_valid = lookup_hit;    // Zero-cycle hit.

	////////////////////
	// Instances
	////////////////////

	icache_controller icache_controller_inst
	(
		.clock        (clock),
		.reset        (reset),
		.fetch_addr   (fetch_addr),
		.lookup_hit   (lookup_hit),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.fill_index   (fill_index),
		.fill_tag     (fill_tag),
		.fill_enable  (fill_enable),
		.lookup_event (lookup_event),
		.miss_event   (miss_event),
		.fill_event   (fill_event)
	);

	icache_mem icache_mem_inst
	(
		.clock        (clock),
		.reset        (reset),
		.lookup_index (lookup_index),
		.lookup_tag   (lookup_tag),
		.fill_enable  (fill_enable),
		.fill_index   (fill_index),
		.fill_tag     (fill_tag),
		.fill_data    (mem_data),    // Bus word goes straight in.
		.lookup_data  (fetch_data),
		.lookup_hit   (lookup_hit)
	);

	icache_perf_counters icache_perf_counters_inst
	(
		.clock        (clock),
		.reset        (reset),
		.lookup_event (lookup_event),
		.miss_event   (miss_event),
		.fill_event   (fill_event),
		.lookup_count (lookup_count),
		.miss_count   (miss_count),
		.fill_count   (fill_count)
	);

endmodule

//--- verilog/icache_perf_counters.sv
`include "icache_settings.svh"

module icache_perf_counters
(
	input  logic               clock,
	input  logic               reset,
	input  logic               lookup_event,
	input  logic               miss_event,
	input  logic               fill_event,
	output icache_pkg::count_t lookup_count,
	output icache_pkg::count_t miss_count,
	output icache_pkg::count_t fill_count
);
	import icache_pkg::*;

	localparam int num_counters = 3;

	count_t                  counts [num_counters];
	logic [num_counters-1:0] events;

	// Slot order: lookups, misses, fills.
	assign events = {fill_event, miss_event, lookup_event};

	////////////////////
	// Counting
	////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_counters; i++)
				counts[i] <= `ICACHE_SD '0;
		end
		else
		begin
			for (int i = 0; i < num_counters; i++)
			begin
				if (events[i] && (counts[i] != '1))
					counts[i] <= `ICACHE_SD counts[i] + 1'b1;    // Stops at all ones.
			end
		end
	end

	////////////////////
	// Outputs
	////////////////////

	assign lookup_count = counts[0];
	assign miss_count   = counts[1];
	assign fill_count   = counts[2];

endmodule

//--- verilog/icache_mem.sv
`include "icache_settings.svh"

module icache_mem
(
	input  logic                clock,
	input  logic                reset,
	input  icache_pkg::index_t  lookup_index,
	input  icache_pkg::tag_t    lookup_tag,
	input  logic                fill_enable,
	input  icache_pkg::index_t  fill_index,
	input  icache_pkg::tag_t    fill_tag,
	input  icache_pkg::word_t   fill_data,
	output icache_pkg::word_t   lookup_data,
	output logic                lookup_hit
);
	import icache_pkg::*;

	word_t                   data_array [`ICACHE_LINES];
	tag_t                    tag_array [`ICACHE_LINES];
	logic [`ICACHE_LINES-1:0] valid_bits;

	////////////////////
	// Lookup
	////////////////////

	// Pure read of the arrays, no clock in the path.
	assign lookup_data = data_array[lookup_index];
	assign lookup_hit  = valid_bits[lookup_index] && (tag_array[lookup_index] == lookup_tag);

	////////////////////
	// Fill
	////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			valid_bits <= `ICACHE_SD '0;    // Empty cache.
		else if (fill_enable)
			valid_bits[fill_index] <= `ICACHE_SD 1'b1;
	end

	// Payload arrays.
	always_ff @(posedge clock)
	begin
		if (fill_enable)
		begin
			data_array[fill_index] <= `ICACHE_SD fill_data;
			tag_array[fill_index]  <= `ICACHE_SD fill_tag;
		end
	end

endmodule

//--- verilog/icache_controller.sv
`include "icache_settings.svh"

module icache_controller
(
	input  logic                      clock,
	input  logic                      reset,
	input  icache_pkg::addr_t         fetch_addr,
	input  logic                      lookup_hit,
	input  icache_pkg::mem_tag_t      mem_response,
	input  icache_pkg::mem_tag_t      mem_tag,
	output icache_pkg::bus_command_t  mem_command,
	output icache_pkg::addr_t         mem_addr,
	output icache_pkg::index_t        fill_index,
	output icache_pkg::tag_t          fill_tag,
	output logic                      fill_enable,
	output logic                      lookup_event,
	output logic                      miss_event,
	output logic                      fill_event
);
	import icache_pkg::*;

	index_t        current_index;
	tag_t          current_tag;
	index_t        last_index;
	tag_t          last_tag;
	mem_tag_t      held_tag;
	icache_state_t state;
	icache_state_t next_state;
	logic          changed_addr;
	logic          accepted;
	logic          tag_match;

	////////////////////
	// Address split
	////////////////////

	assign current_index = fetch_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
	assign current_tag   = fetch_addr[`ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS +: `ICACHE_TAG_BITS];

	assign changed_addr = (current_index != last_index) || (current_tag != last_tag);

	////////////////////
	// Bus side
	////////////////////

	assign mem_addr    = {fetch_addr[63:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
	assign mem_command = (state == state_request && !changed_addr) ? bus_load : bus_none;
	assign accepted    = (mem_command == bus_load) && (mem_response != '0);    // Tag granted.

	// Data belongs to us only while the tag is live.
	assign tag_match   = (state == state_wait_data) && (held_tag != '0) && (mem_tag == held_tag);
	assign fill_enable = tag_match && !changed_addr;    // Dropped if the fetch moved on.

	// Address is stable in the miss states, so the previous one is the miss line.
	assign fill_index = last_index;
	assign fill_tag   = last_tag;

	assign lookup_event = changed_addr;
	assign miss_event   = accepted;
	assign fill_event   = fill_enable;

	////////////////////
	// Miss FSM
	////////////////////

	always_comb
	begin
		next_state = state;
		case (state)
			state_idle:
			begin
				if (!lookup_hit)
					next_state = state_request;    // Start a load.
			end
			state_request:
			begin
				if (changed_addr)
					next_state = lookup_hit ? state_idle : state_request;
				else if (accepted)
					next_state = state_wait_data;
			end
			state_wait_data:
			begin
				if (changed_addr)
					next_state = lookup_hit ? state_idle : state_request;
				else if (fill_enable)
					next_state = state_idle;    // Line written this cycle.
			end
			default:
				next_state = state_idle;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state      <= `ICACHE_SD state_idle;
			last_index <= `ICACHE_SD '1;    // First fetch reads as a change.
			last_tag   <= `ICACHE_SD '1;
			held_tag   <= `ICACHE_SD '0;
		end
		else
		begin
			state      <= `ICACHE_SD next_state;
			last_index <= `ICACHE_SD current_index;
			last_tag   <= `ICACHE_SD current_tag;
			if (accepted)
				held_tag <= `ICACHE_SD mem_response;
			else if (changed_addr || tag_match)
				held_tag <= `ICACHE_SD '0;    // Done or abandoned.
		end
	end

endmodule

//--- verilog/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

	////////////////////
	// Vector types
	////////////////////

	typedef logic [63:0] addr_t;                           // Fetch and bus address.
	typedef logic [63:0] word_t;                           // Instruction word.
	typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;        // Line index.
	typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;            // Cache tag.
	typedef logic [`ICACHE_MEM_TAG_BITS-1:0] mem_tag_t;    // Bus transaction tag.
	typedef logic [`ICACHE_COUNT_BITS-1:0] count_t;        // Performance count.

	////////////////////
	// Enumerations
	////////////////////

	typedef enum logic [1:0]
	{
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} bus_command_t;

	typedef enum logic [1:0]
	{
		state_idle      = 2'h0,    // Line present or no fetch in progress.
		state_request   = 2'h1,    // Load on the bus, waiting for a tag.
		state_wait_data = 2'h2     // Tag held, waiting for the data.
	} icache_state_t;

endpackage

//--- include/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

////////////////////
// Timing
////////////////////

`define ICACHE_SD #1                 // Flop output delay.

////////////////////
// Geometry
////////////////////

// ICACHE_LINES and ICACHE_INDEX_BITS move together.
`define ICACHE_LINES        32       // One word per line.
`define ICACHE_OFFSET_BITS  3        // Byte offset in a 64-bit word.
`define ICACHE_INDEX_BITS   5        // Line select.
`define ICACHE_TAG_BITS     8        // Stored tag.

////////////////////
// Bus and counters
////////////////////

`define ICACHE_MEM_TAG_BITS 4        // Zero means no transaction.
`define ICACHE_COUNT_BITS   16       // Saturating counters.

`endif
